//--- build.f
dbg_link_pkg.sv
dbg_uart_pkg.sv
dbg_link_tx.sv
dbg_link_rx.sv
dbg_node.sv
dbg_frame_sender.sv
dbg_frame_receiver.sv
dbg_chain_top.sv
tb_dbg_checker.sv
tb_dbg_chain.sv

//--- Bender.yml
package:
  name: dbg_chain

sources:
  - dbg_link_pkg.sv
  - dbg_uart_pkg.sv
  - dbg_link_tx.sv
  - dbg_link_rx.sv
  - dbg_node.sv
  - dbg_frame_sender.sv
  - dbg_frame_receiver.sv
  - dbg_chain_top.sv
  - target: test
    files:
      - tb_dbg_checker.sv
      - tb_dbg_chain.sv

//--- tb_dbg_chain.sv
`timescale 1ns/1ns

module tb_dbg_chain;
    import dbg_link_pkg::*;
    import dbg_uart_pkg::*;

    localparam int ROWS = 19;
    // request, five link hops and response, per row.
    localparam int ROW_CYCLES = 2 * 60 * CLKS_PER_BIT
        + (NODE_COUNT + 1) * (FRAME_BITS * 2 * LINK_PRESCALE + 2);
    localparam int CYCLE_LIMIT = 2 * ROWS * ROW_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        uart_rx;
    logic        uart_tx;
    logic [3:0]  led;
    logic        resp_done;
    int          data_errors;
    int          led_errors;
    int          line_errors;
    int          cycles = 0;
    int          row_count;

    logic [7:0]  row_op   [ROWS];
    logic [7:0]  row_addr [ROWS];
    logic [31:0] row_data [ROWS];
    logic [31:0] row_resp [ROWS];
    logic [3:0]  row_led  [ROWS];

    logic [7:0]  cur_op;
    logic [7:0]  cur_addr;
    logic [31:0] cur_resp;
    logic [3:0]  cur_led;

    dbg_chain_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .uart_rx(uart_rx),
        .uart_tx(uart_tx),
        .led    (led)
    );

    tb_dbg_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .uart_tx    (uart_tx),
        .led        (led),
        .exp_op     (cur_op),
        .exp_addr   (cur_addr),
        .exp_data   (cur_resp),
        .exp_led    (cur_led),
        .resp_done  (resp_done),
        .data_errors(data_errors),
        .led_errors (led_errors),
        .line_errors(line_errors)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic add_row(input logic [7:0] op, input logic [7:0] addr,
                           input logic [31:0] data, input logic [31:0] resp,
                           input logic [3:0] led_exp);
        row_op[row_count] = op;
        row_addr[row_count] = addr;
        row_data[row_count] = data;
        row_resp[row_count] = resp;
        row_led[row_count] = led_exp;
        row_count++;
    endtask

    // 8N1, lsb first, one bit per CLKS_PER_BIT cycles.
    task automatic send_byte(input logic [7:0] b);
        int i;
        uart_rx <= 1'b0;
        repeat (CLKS_PER_BIT) @(posedge clk);
        for (i = 0; i < 8; i++) begin
            uart_rx <= b[i];
            repeat (CLKS_PER_BIT) @(posedge clk);
        end
        uart_rx <= 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic report_and_finish(input logic timed_out);
        $display("errors: data %0d, led %0d, line %0d",
                 data_errors, led_errors, line_errors);
        if (!timed_out && data_errors + led_errors + line_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // ====================
    // request table
    // ====================

    initial begin
        int r;
        row_count = 0;
        rst_n = 1'b0;
        uart_rx = 1'b1;
        cur_op = '0;
        cur_addr = '0;
        cur_resp = '0;
        cur_led = 4'hF;

        add_row(OP_IDENT, 8'd0, 32'h0000_0000, 32'h1122_3300, 4'hF);
        add_row(OP_IDENT, 8'd1, 32'hFFFF_FFFF, 32'h1122_3301, 4'hF);
        add_row(OP_IDENT, 8'd2, 32'h0000_0000, 32'h1122_3302, 4'hF);
        add_row(OP_IDENT, 8'd3, 32'h1234_0000, 32'h1122_3303, 4'hF);
        add_row(OP_WRITE, 8'd2, 32'hCAFE_F00D, 32'hCAFE_F00D, 4'hF);
        add_row(OP_READ,  8'd2, 32'h0000_0000, 32'hCAFE_F00D, 4'hF);
        add_row(OP_WRITE, 8'd1, 32'h1234_5678, 32'h1234_5678, 4'hF);
        add_row(OP_WRITE, 8'd3, 32'h9ABC_DEF0, 32'h9ABC_DEF0, 4'hF);
        add_row(OP_READ,  8'd1, 32'h0000_0000, 32'h1234_5678, 4'hF);
        add_row(OP_READ,  8'd3, 32'h0000_0000, 32'h9ABC_DEF0, 4'hF);
        add_row(OP_READ,  8'd2, 32'h0000_0000, 32'hCAFE_F00D, 4'hF);
        add_row(OP_WRITE, 8'd0, 32'h0000_00A5, 32'h0000_00A5, 4'hA);
        add_row(OP_READ,  8'd0, 32'h0000_0000, 32'h0000_00A5, 4'hA);
        // out of range address and unknown opcode pass through.
        add_row(OP_WRITE, 8'd4, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 4'hA);
        add_row(OP_READ,  8'hF0, 32'h55AA_55AA, 32'h55AA_55AA, 4'hA);
        add_row(8'h7E,    8'd0, 32'h0F0F_0F0F, 32'h0F0F_0F0F, 4'hA);
        add_row(OP_READ,  8'd0, 32'h0000_0000, 32'h0000_00A5, 4'hA);
        add_row(OP_READ,  8'd1, 32'h0000_0000, 32'h1234_5678, 4'hA);
        add_row(OP_WRITE, 8'd0, 32'hFFFF_FFF3, 32'hFFFF_FFF3, 4'hC);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        for (r = 0; r < ROWS; r++) begin
            cur_op = row_op[r];
            cur_addr = row_addr[r];
            cur_resp = row_resp[r];
            cur_led = row_led[r];
            send_byte(row_op[r]);
            send_byte(row_addr[r]);
            send_byte(row_data[r][31:24]);
            send_byte(row_data[r][23:16]);
            send_byte(row_data[r][15:8]);
            send_byte(row_data[r][7:0]);
            while (!resp_done) @(posedge clk);
            @(posedge clk);
        end
        report_and_finish(1'b0);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            report_and_finish(1'b1);
        end
    end

endmodule

//--- tb_dbg_checker.sv
`timescale 1ns/1ns

module tb_dbg_checker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               uart_tx,
    input  logic [3:0]                         led,
    input  logic [dbg_link_pkg::OP_BITS-1:0]   exp_op,
    input  logic [dbg_link_pkg::ADDR_BITS-1:0] exp_addr,
    input  logic [dbg_link_pkg::DATA_BITS-1:0] exp_data,
    input  logic [3:0]                         exp_led,
    output logic                               resp_done,
    output int                                 data_errors,
    output int                                 led_errors,
    output int                                 line_errors
);
    import dbg_link_pkg::*;
    import dbg_uart_pkg::*;

    // sampled on the falling clock edge, mid-bit.
    task automatic receive_byte(output logic [7:0] b);
        int i;
        b = '0;
        do @(negedge clk); while (!(rst_n && uart_tx === 1'b0));
        repeat (HALF_BIT) @(negedge clk);
        if (uart_tx !== 1'b0) begin
            $display("uart_tx start bit did not stay low");
            line_errors++;
        end
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx !== 1'b1) begin
            $display("uart_tx stop bit missing");
            line_errors++;
        end
    endtask

    task automatic compare_response(input logic [FRAME_BITS-1:0] resp);
        if (resp[FRAME_BITS-1 -: OP_BITS] !== exp_op) begin
            $display("CHECK FAILED uart_tx opcode: got %h expected %h",
                     resp[FRAME_BITS-1 -: OP_BITS], exp_op);
            data_errors++;
        end
        if (resp[DATA_BITS +: ADDR_BITS] !== exp_addr) begin
            $display("CHECK FAILED uart_tx address: got %h expected %h",
                     resp[DATA_BITS +: ADDR_BITS], exp_addr);
            data_errors++;
        end
        if (resp[DATA_BITS-1:0] !== exp_data) begin
            $display("CHECK FAILED uart_tx data: got %h expected %h",
                     resp[DATA_BITS-1:0], exp_data);
            data_errors++;
        end
        if (led !== exp_led) begin
            $display("CHECK FAILED led: got %h expected %h", led, exp_led);
            led_errors++;
        end
    endtask

    initial begin
        logic [7:0]            b;
        logic [FRAME_BITS-1:0] resp;
        int                    n;
        resp_done = 1'b0;
        data_errors = 0;
        led_errors = 0;
        line_errors = 0;
        resp = '0;
        @(posedge rst_n);
        @(negedge clk);
        if (led !== 4'hF) begin
            $display("CHECK FAILED led after reset: got %h expected %h", led, 4'hF);
            led_errors++;
        end
        forever begin
            for (n = 0; n < FRAME_BYTES; n++) begin
                receive_byte(b);
                resp = {resp[FRAME_BITS-9:0], b};
            end
            // end of the last stop bit.
            repeat (HALF_BIT) @(negedge clk);
            compare_response(resp);
            resp_done = 1'b1;
            @(negedge clk);
            resp_done = 1'b0;
        end
    end

endmodule

//--- dbg_chain_top.sv
`timescale 1ns/1ns

module dbg_chain_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic [3:0] led
);
    import dbg_link_pkg::*;

    // link i feeds node i; link NODE_COUNT feeds the receiver.
    logic [NODE_COUNT:0]  link_data;
    logic [NODE_COUNT:0]  link_strobe;
    logic [NODE_COUNT:0]  link_frame;
    logic [DATA_BITS-1:0] debug_reg [NODE_COUNT];

    dbg_frame_sender u_sender (
        .clk        (clk),
        .rst_n      (rst_n),
        .uart_rx    (uart_rx),
        .link_data  (link_data[0]),
        .link_strobe(link_strobe[0]),
        .link_frame (link_frame[0])
    );

    for (genvar i = 0; i < NODE_COUNT; i++) begin : g_node
        dbg_node #(
            .NODE_INDEX(i)
        ) u_node (
            .clk      (clk),
            .rst_n    (rst_n),
            .rx_data  (link_data[i]),
            .rx_strobe(link_strobe[i]),
            .rx_frame (link_frame[i]),
            .tx_data  (link_data[i+1]),
            .tx_strobe(link_strobe[i+1]),
            .tx_frame (link_frame[i+1]),
            .debug_reg(debug_reg[i])
        );
    end

    dbg_frame_receiver u_receiver (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_data  (link_data[NODE_COUNT]),
        .link_strobe(link_strobe[NODE_COUNT]),
        .link_frame (link_frame[NODE_COUNT]),
        .uart_tx    (uart_tx)
    );

    // leds are active low.
    assign led = ~debug_reg[0][3:0];

endmodule

//--- dbg_frame_receiver.sv
`timescale 1ns/1ns

module dbg_frame_receiver (
    input  logic clk,
    input  logic rst_n,
    input  logic link_data,
    input  logic link_strobe,
    input  logic link_frame,
    output logic uart_tx
);
    import dbg_link_pkg::*;
    import dbg_uart_pkg::*;

    logic [FRAME_BITS-1:0]    frame;
    logic                     frame_valid;
    logic [FRAME_BITS-1:0]    out_q;
    logic [7:0]               tx_byte;
    uart_state_e              state;
    logic [UART_CNT_BITS-1:0] clk_cnt;
    logic [2:0]               bit_idx;
    logic [BYTE_CNT_BITS-1:0] byte_cnt;
    logic                     sending;
    logic                     bit_end;

    dbg_link_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_data  (link_data),
        .link_strobe(link_strobe),
        .link_frame (link_frame),
        .frame      (frame),
        .frame_valid(frame_valid)
    );

    assign tx_byte = out_q[FRAME_BITS-1 -: 8];
    assign bit_end = (clk_cnt == UART_CNT_BITS'(CLKS_PER_BIT - 1));

    // ====================
    // uart transmitter
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            uart_tx <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
            byte_cnt <= '0;
            sending <= 1'b0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (sending) begin
                        state <= START;
                        uart_tx <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state <= DATA;
                        bit_idx <= '0;
                        uart_tx <= tx_byte[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            uart_tx <= tx_byte[bit_idx + 3'd1];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state <= IDLE;
                        if (byte_cnt == BYTE_CNT_BITS'(FRAME_BYTES - 1)) begin
                            byte_cnt <= '0;
                            sending <= 1'b0;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
            if (frame_valid) begin
                sending <= 1'b1;
            end
        end
    end

    // bytes leave msb first.
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            out_q <= frame;
        end else if (state == STOP && bit_end) begin
            out_q <= {out_q[FRAME_BITS-9:0], 8'h00};
        end
    end

    // the host waits for each response before it sends the next request.
    a_no_frame_while_sending: assert property (@(posedge clk) disable iff (!rst_n)
        frame_valid |-> !sending);

endmodule

//--- dbg_frame_sender.sv
`timescale 1ns/1ns

module dbg_frame_sender (
    input  logic clk,
    input  logic rst_n,
    input  logic uart_rx,
    output logic link_data,
    output logic link_strobe,
    output logic link_frame
);
    import dbg_link_pkg::*;
    import dbg_uart_pkg::*;

    logic [1:0]               rx_sync;
    logic                     rx_s;
    uart_state_e              state;
    logic [UART_CNT_BITS-1:0] clk_cnt;
    logic [2:0]               bit_idx;
    logic [BYTE_CNT_BITS-1:0] byte_cnt;
    logic [7:0]               byte_q;
    logic [FRAME_BITS-1:0]    frame_q;
    logic                     load;

    // two-flop synchroniser.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
        end
    end

    assign rx_s = rx_sync[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            byte_cnt <= '0;
            load <= 1'b0;
        end else begin
            load <= 1'b0;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_s) begin
                        state <= START;
                    end
                end
                START: begin
                    if (clk_cnt == UART_CNT_BITS'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch on the line, not a start bit.
                        state <= rx_s ? IDLE : DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (clk_cnt == UART_CNT_BITS'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (clk_cnt == UART_CNT_BITS'(CLKS_PER_BIT - 1)) begin
                        state <= IDLE;
                        if (rx_s) begin
                            if (byte_cnt == BYTE_CNT_BITS'(FRAME_BYTES - 1)) begin
                                byte_cnt <= '0;
                                load <= 1'b1;
                            end else begin
                                byte_cnt <= byte_cnt + 1'b1;
                            end
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb first on the line, first byte ends up on top of the frame.
    always_ff @(posedge clk) begin
        if (state == DATA && clk_cnt == UART_CNT_BITS'(CLKS_PER_BIT - 1)) begin
            byte_q <= {rx_s, byte_q[7:1]};
        end
        if (state == STOP && clk_cnt == UART_CNT_BITS'(CLKS_PER_BIT - 1) && rx_s) begin
            frame_q <= {frame_q[FRAME_BITS-9:0], byte_q};
        end
    end

    dbg_link_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .frame      (frame_q),
        .busy       (),
        .link_data  (link_data),
        .link_strobe(link_strobe),
        .link_frame (link_frame)
    );

endmodule

//--- dbg_node.sv
`timescale 1ns/1ns

module dbg_node #(
    parameter int NODE_INDEX = 0
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               rx_data,
    input  logic                               rx_strobe,
    input  logic                               rx_frame,
    output logic                               tx_data,
    output logic                               tx_strobe,
    output logic                               tx_frame,
    output logic [dbg_link_pkg::DATA_BITS-1:0] debug_reg
);
    import dbg_link_pkg::*;

    logic [FRAME_BITS-1:0] rx_word;
    logic [FRAME_BITS-1:0] tx_word;
    logic                  rx_valid;
    logic                  tx_load;
    dbg_op_e               op;
    logic [ADDR_BITS-1:0]  addr;
    logic [DATA_BITS-1:0]  data_in;
    logic [DATA_BITS-1:0]  data_out;
    logic                  hit;

    dbg_link_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_data  (rx_data),
        .link_strobe(rx_strobe),
        .link_frame (rx_frame),
        .frame      (rx_word),
        .frame_valid(rx_valid)
    );

    assign op = dbg_op_e'(rx_word[FRAME_BITS-1 -: OP_BITS]);
    assign addr = rx_word[DATA_BITS +: ADDR_BITS];
    assign data_in = rx_word[DATA_BITS-1:0];
    assign hit = (addr == ADDR_BITS'(NODE_INDEX));

    always_comb begin
        data_out = data_in;
        if (hit) begin
            case (op)
                OP_READ:  data_out = debug_reg;
                OP_IDENT: data_out = IDENT_BASE + DATA_BITS'(NODE_INDEX);
                default:  data_out = data_in;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_reg <= '0;
            tx_load <= 1'b0;
        end else begin
            tx_load <= rx_valid;
            if (rx_valid && hit && op == OP_WRITE) begin
                debug_reg <= data_in;
            end
        end
    end

    // opcode and address travel on untouched.
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            tx_word <= {rx_word[FRAME_BITS-1:DATA_BITS], data_out};
        end
    end

    dbg_link_tx u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (tx_load),
        .frame      (tx_word),
        .busy       (),
        .link_data  (tx_data),
        .link_strobe(tx_strobe),
        .link_frame (tx_frame)
    );

endmodule

//--- dbg_link_rx.sv
`timescale 1ns/1ns

module dbg_link_rx (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                link_data,
    input  logic                                link_strobe,
    input  logic                                link_frame,
    output logic [dbg_link_pkg::FRAME_BITS-1:0] frame,
    output logic                                frame_valid
);
    import dbg_link_pkg::*;

    logic                  strobe_q;
    logic                  frame_q;
    logic [FRAME_BITS-1:0] shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strobe_q <= 1'b0;
            frame_q <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            strobe_q <= link_strobe;
            frame_q <= link_frame;
            // falling edge of the frame line.
            frame_valid <= frame_q & ~link_frame;
        end
    end

    // sample on the strobe rising edge.
    always_ff @(posedge clk) begin
        if (link_frame && link_strobe && !strobe_q) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], link_data};
        end
    end

    assign frame = shift_q;

endmodule

//--- dbg_link_tx.sv
`timescale 1ns/1ns

module dbg_link_tx (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load,
    input  logic [dbg_link_pkg::FRAME_BITS-1:0] frame,
    output logic                                busy,
    output logic                                link_data,
    output logic                                link_strobe,
    output logic                                link_frame
);
    import dbg_link_pkg::*;

    logic [LINK_CNT_BITS-1:0]  pre_cnt;
    logic [FRAME_CNT_BITS-1:0] bit_cnt;
    logic [FRAME_BITS-1:0]     shift_q;
    logic                      bit_end;

    assign bit_end = (pre_cnt == LINK_CNT_BITS'(2 * LINK_PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            link_frame <= 1'b0;
            link_strobe <= 1'b0;
            pre_cnt <= '0;
            bit_cnt <= '0;
        end else if (load) begin
            busy <= 1'b1;
            link_frame <= 1'b1;
            link_strobe <= 1'b0;
            pre_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                pre_cnt <= '0;
                link_strobe <= 1'b0;
                if (bit_cnt == FRAME_CNT_BITS'(FRAME_BITS - 1)) begin
                    busy <= 1'b0;
                    link_frame <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
                // strobe covers the second half of the bit.
                if (pre_cnt == LINK_CNT_BITS'(LINK_PRESCALE - 1)) begin
                    link_strobe <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= frame;
        end else if (busy && bit_end) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    assign link_data = shift_q[FRAME_BITS-1];

    // upstream must not hand over a frame before the previous one has left.
    a_no_load_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> !busy);

endmodule

//--- dbg_uart_pkg.sv
package dbg_uart_pkg;

    localparam int CLKS_PER_BIT = 16;
    localparam int HALF_BIT = CLKS_PER_BIT / 2;
    localparam int UART_CNT_BITS = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

endpackage

//--- dbg_link_pkg.sv
package dbg_link_pkg;

    // ====================
    // frame layout
    // ====================

    localparam int FRAME_BITS = 48;
    localparam int DATA_BITS = 32;
    localparam int ADDR_BITS = 8;
    localparam int OP_BITS = 8;

    // frame is carried over the uart as whole bytes.
    localparam int FRAME_BYTES = FRAME_BITS / 8;
    localparam int BYTE_CNT_BITS = $clog2(FRAME_BYTES);
    localparam int FRAME_CNT_BITS = $clog2(FRAME_BITS);

    // ====================
    // chain
    // ====================

    localparam int NODE_COUNT = 4;
    localparam logic [DATA_BITS-1:0] IDENT_BASE = 32'h11223300;

    // half a link bit, in clock cycles.
    localparam int LINK_PRESCALE = 4;
    localparam int LINK_CNT_BITS = $clog2(2 * LINK_PRESCALE);

    typedef enum logic [OP_BITS-1:0] {
        OP_WRITE = 8'h01,
        OP_READ  = 8'h02,
        OP_IDENT = 8'h03
    } dbg_op_e;

endpackage
